/* mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define XLEN 32

// bytes in one data word
`define MEM_BYTES 4

// uncached i/o window starts here and runs to the top of the map
`define IO_BASE 32'hF000_0000

// architectural register index
`define RD_BITS 5

// reorder tag carried along with each micro-op
`define TAG_BITS 4

`endif

/* dbus_pkg.sv */
`include "mem_defs.svh"

package dbus_pkg;

    // one data word on the l1 port
    typedef logic [`XLEN-1:0] word_t;

    // write enable per byte lane
    typedef logic [`MEM_BYTES-1:0] byte_mask_t;

    // byte offset inside a word
    localparam int unsigned OFF_BITS = $clog2(`MEM_BYTES);

    localparam byte_mask_t MASK_NONE = '0;
    localparam byte_mask_t MASK_ALL  = '1;

    // word aligned form of a byte address
    function automatic word_t word_addr(word_t addr);
        return {addr[`XLEN-1:OFF_BITS], {OFF_BITS{1'b0}}};
    endfunction

    // i/o window bypasses the cache
    function automatic logic is_uncached(word_t addr);
        return addr >= `IO_BASE;
    endfunction

endpackage

/* uop_pkg.sv */
`include "mem_defs.svh"

package uop_pkg;

    // memory op code as it leaves decode
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LBU  = 4'd2,
        LH   = 4'd3,
        LHU  = 4'd4,
        LW   = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    typedef logic [`TAG_BITS-1:0] tag_t;

    function automatic logic is_load(mem_op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    // anything that has to go out to the cache
    function automatic logic is_mem(mem_op_e op);
        return is_load(op) || is_store(op);
    endfunction

    function automatic logic is_half(mem_op_e op);
        return op inside {LH, LHU, SH};
    endfunction

    function automatic logic is_word(mem_op_e op);
        return op inside {LW, SW};
    endfunction

endpackage

/* store_format.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module store_format (
    input  uop_pkg::mem_op_e    op_i,
    input  logic [1:0]          addr_lo_i,
    input  dbus_pkg::word_t     rs2_i,
    output dbus_pkg::word_t     data_o,
    output dbus_pkg::byte_mask_t mask_o
);

    import uop_pkg::*;
    import dbus_pkg::*;

    logic [7:0]  st_byte;
    logic [15:0] st_half;

    assign st_byte = rs2_i[7:0];
    assign st_half = rs2_i[15:0];

    always_comb begin
        data_o = rs2_i;
        mask_o = MASK_NONE; // loads never write

        case (op_i)
            SB: begin
                // same byte in every lane, mask picks the one
                data_o = {`MEM_BYTES{st_byte}};
                mask_o = byte_mask_t'(1) << addr_lo_i;
            end
            SH: begin
                data_o = {(`MEM_BYTES/2){st_half}};
                mask_o = byte_mask_t'(2'b11) << {addr_lo_i[1], 1'b0}; // low or high half
            end
            SW: begin
                data_o = rs2_i;
                mask_o = MASK_ALL;
            end
            default: begin
                data_o = rs2_i;
                mask_o = MASK_NONE;
            end
        endcase
    end

endmodule

/* load_align.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module load_align (
    input  uop_pkg::mem_op_e    op_i,
    input  logic [1:0]          addr_lo_i,
    input  dbus_pkg::word_t     word_i,
    output dbus_pkg::word_t     value_o
);

    import uop_pkg::*;
    import dbus_pkg::*;

    word_t       shifted;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // bring the addressed lane down to bit 0
    assign shifted = word_i >> {addr_lo_i, 3'b000};
    assign ld_byte = shifted[7:0];
    assign ld_half = shifted[15:0];

    always_comb begin
        case (op_i)
            LB: begin
                value_o = {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            end
            LBU: begin
                value_o = {{(`XLEN-8){1'b0}}, ld_byte};
            end
            LH: begin
                value_o = {{(`XLEN-16){ld_half[15]}}, ld_half};
            end
            LHU: begin
                value_o = {{(`XLEN-16){1'b0}}, ld_half};
            end
            default: begin
                value_o = word_i; // lw, whole word as returned
            end
        endcase
    end

endmodule

/* dbus_port.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module dbus_port (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // from the control module and the formatter
    input  logic                    issue_i,
    input  logic                    write_i,
    input  logic [`XLEN-1:0]        addr_i,
    input  dbus_pkg::word_t         wdata_i,
    input  dbus_pkg::byte_mask_t    mask_i,
    input  logic                    waiting_i,
    output logic                    accepted_o,
    output logic                    resp_valid_o,
    output dbus_pkg::word_t         resp_data_o,

    // l1 data cache request
    output logic                    l1d_req_valid_o,
    output logic [`XLEN-1:0]        l1d_req_addr_o,
    output logic                    l1d_req_write_o,
    output dbus_pkg::word_t         l1d_req_data_o,
    output dbus_pkg::byte_mask_t    l1d_req_mask_o,
    output logic                    l1d_req_uncached_o,
    input  logic                    l1d_req_ready_i,

    // l1 data cache response
    input  logic                    l1d_resp_valid_i,
    input  dbus_pkg::word_t         l1d_resp_data_i,
    output logic                    l1d_resp_ready_o
);

    import dbus_pkg::*;

    logic       pending_q;  // issued, cache has not taken it yet
    word_t      addr_q;
    logic       write_q;
    word_t      wdata_q;
    byte_mask_t mask_q;

    // first cycle goes straight from the inputs, later cycles from the copy
    assign l1d_req_valid_o = issue_i | pending_q;
    assign l1d_req_addr_o  = pending_q ? addr_q  : word_addr(addr_i);
    assign l1d_req_write_o = pending_q ? write_q : write_i;
    assign l1d_req_data_o  = pending_q ? wdata_q : wdata_i;
    assign l1d_req_mask_o  = pending_q ? mask_q  : mask_i;

    assign l1d_req_uncached_o = is_uncached(l1d_req_addr_o);

    assign accepted_o = l1d_req_valid_o & l1d_req_ready_i;

    // response side, ready only while a load is outstanding
    assign l1d_resp_ready_o = waiting_i;
    assign resp_valid_o     = l1d_resp_valid_i;
    assign resp_data_o      = l1d_resp_data_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pending_q <= 1'b0;
        end else if (accepted_o) begin
            pending_q <= 1'b0;
        end else if (issue_i) begin
            pending_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            addr_q  <= word_addr(addr_i);
            write_q <= write_i;
            wdata_q <= wdata_i;
            mask_q  <= mask_i;
        end
    end

    // request must not move under a stalled cache
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l1d_req_valid_o && !l1d_req_ready_i |=>
            l1d_req_valid_o && $stable(l1d_req_addr_o) && $stable(l1d_req_write_o)
            && $stable(l1d_req_data_o) && $stable(l1d_req_mask_o));

endmodule

/* mem_stage_ctrl.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_stage_ctrl (
    input  logic                clk_i,
    input  logic                rstn_i,

    input  logic                uop_valid_i,
    input  uop_pkg::mem_op_e    uop_op_i,
    input  logic [`XLEN-1:0]    uop_addr_i,
    input  logic [`RD_BITS-1:0] uop_rd_i,
    input  uop_pkg::tag_t       uop_tag_i,

    input  logic                accepted_i,
    input  logic                resp_valid_i,
    input  logic [`XLEN-1:0]    load_data_i,

    output logic                issue_o,
    output logic                issue_write_o,
    output logic                waiting_o,
    output logic                stall_o,

    output logic                wb_valid_o,
    output logic                wb_we_o,
    output logic [`RD_BITS-1:0] wb_rd_o,
    output logic [`XLEN-1:0]    wb_data_o,
    output uop_pkg::tag_t       wb_tag_o
);

    import uop_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REQ,    // issued and waiting for the cache to take it
        WAIT    // load out and waiting for data
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   wb_fire;    // uop retires into the writeback regs this edge

    always_comb begin
        state_d = state_q;
        issue_o = 1'b0;
        stall_o = 1'b0;
        wb_fire = 1'b0;

        case (state_q)
            IDLE: begin
                if (uop_valid_i && is_mem(uop_op_i)) begin
                    issue_o = 1'b1;
                    if (!accepted_i) begin
                        stall_o = 1'b1;
                        state_d = REQ;
                    end else if (is_load(uop_op_i)) begin
                        stall_o = 1'b1;
                        state_d = WAIT;
                    end else begin
                        wb_fire = 1'b1; // store taken on first try
                    end
                end else if (uop_valid_i) begin
                    wb_fire = 1'b1;
                end
            end
            REQ: begin
                stall_o = 1'b1;
                if (accepted_i && is_load(uop_op_i)) begin
                    state_d = WAIT;
                end else if (accepted_i) begin
                    stall_o = 1'b0;
                    wb_fire = 1'b1;
                    state_d = IDLE;
                end
            end
            WAIT: begin
                stall_o = !resp_valid_i;
                if (resp_valid_i) begin
                    wb_fire = 1'b1;
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign issue_write_o = is_store(uop_op_i);
    assign waiting_o     = (state_q == WAIT);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= IDLE;
            wb_valid_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            wb_valid_o <= wb_fire;
        end
    end

    // alu result rides on the address bus for non-memory ops
    always_ff @(posedge clk_i) begin
        if (wb_fire) begin
            wb_we_o   <= !is_store(uop_op_i);
            wb_rd_o   <= uop_rd_i;
            wb_tag_o  <= uop_tag_i;
            wb_data_o <= is_load(uop_op_i) ? load_data_i : uop_addr_i;
        end
    end

    a_half_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        uop_valid_i && is_half(uop_op_i) |-> !uop_addr_i[0]);

    a_word_aligned: assert property (@(posedge clk_i) disable iff (!rstn_i)
        uop_valid_i && is_word(uop_op_i) |-> uop_addr_i[1:0] == 2'b00);

    // cache may only answer a load we are waiting on
    a_resp_in_wait: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> state_q == WAIT);

endmodule

/* mem_stage.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module mem_stage (
    input  logic                    clk_i,
    input  logic                    rstn_i,

    // from the execute stage
    input  logic                    uop_valid_i,
    input  uop_pkg::mem_op_e        uop_op_i,
    input  logic [`XLEN-1:0]        uop_addr_i,
    input  logic [`XLEN-1:0]        uop_wdata_i,
    input  logic [`RD_BITS-1:0]     uop_rd_i,
    input  uop_pkg::tag_t           uop_tag_i,
    output logic                    stall_o,

    // to writeback
    output logic                    wb_valid_o,
    output logic                    wb_we_o,
    output logic [`RD_BITS-1:0]     wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o,
    output uop_pkg::tag_t           wb_tag_o,

    // l1 data cache
    output logic                    l1d_req_valid_o,
    output logic [`XLEN-1:0]        l1d_req_addr_o,
    output logic                    l1d_req_write_o,
    output dbus_pkg::word_t         l1d_req_data_o,
    output dbus_pkg::byte_mask_t    l1d_req_mask_o,
    output logic                    l1d_req_uncached_o,
    input  logic                    l1d_req_ready_i,
    input  logic                    l1d_resp_valid_i,
    input  dbus_pkg::word_t         l1d_resp_data_i,
    output logic                    l1d_resp_ready_o
);

    import dbus_pkg::*;

    logic       issue;
    logic       issue_write;
    logic       waiting;
    logic       accepted;
    logic       resp_valid;
    word_t      resp_data;
    word_t      load_value;
    word_t      st_data;
    byte_mask_t st_mask;

    mem_stage_ctrl u_ctrl (
        .clk_i          ( clk_i         ),
        .rstn_i         ( rstn_i        ),
        .uop_valid_i    ( uop_valid_i   ),
        .uop_op_i       ( uop_op_i      ),
        .uop_addr_i     ( uop_addr_i    ),
        .uop_rd_i       ( uop_rd_i      ),
        .uop_tag_i      ( uop_tag_i     ),
        .accepted_i     ( accepted      ),
        .resp_valid_i   ( resp_valid    ),
        .load_data_i    ( load_value    ),
        .issue_o        ( issue         ),
        .issue_write_o  ( issue_write   ),
        .waiting_o      ( waiting       ),
        .stall_o        ( stall_o       ),
        .wb_valid_o     ( wb_valid_o    ),
        .wb_we_o        ( wb_we_o       ),
        .wb_rd_o        ( wb_rd_o       ),
        .wb_data_o      ( wb_data_o     ),
        .wb_tag_o       ( wb_tag_o      )
    );

    dbus_port u_dbus (
        .clk_i              ( clk_i              ),
        .rstn_i             ( rstn_i             ),
        .issue_i            ( issue              ),
        .write_i            ( issue_write        ),
        .addr_i             ( uop_addr_i         ),
        .wdata_i            ( st_data            ),
        .mask_i             ( st_mask            ),
        .waiting_i          ( waiting            ),
        .accepted_o         ( accepted           ),
        .resp_valid_o       ( resp_valid         ),
        .resp_data_o        ( resp_data          ),
        .l1d_req_valid_o    ( l1d_req_valid_o    ),
        .l1d_req_addr_o     ( l1d_req_addr_o     ),
        .l1d_req_write_o    ( l1d_req_write_o    ),
        .l1d_req_data_o     ( l1d_req_data_o     ),
        .l1d_req_mask_o     ( l1d_req_mask_o     ),
        .l1d_req_uncached_o ( l1d_req_uncached_o ),
        .l1d_req_ready_i    ( l1d_req_ready_i    ),
        .l1d_resp_valid_i   ( l1d_resp_valid_i   ),
        .l1d_resp_data_i    ( l1d_resp_data_i    ),
        .l1d_resp_ready_o   ( l1d_resp_ready_o   )
    );

    // upstream holds the uop while stalled, so both formatters read it directly
    store_format u_store_fmt (
        .op_i       ( uop_op_i          ),
        .addr_lo_i  ( uop_addr_i[1:0]   ),
        .rs2_i      ( uop_wdata_i       ),
        .data_o     ( st_data           ),
        .mask_o     ( st_mask           )
    );

    load_align u_load_align (
        .op_i       ( uop_op_i          ),
        .addr_lo_i  ( uop_addr_i[1:0]   ),
        .word_i     ( resp_data         ),
        .value_o    ( load_value        )
    );

endmodule

/* tb_dcache_model.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module tb_dcache_model (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 hold_ready_i,   // test forces ready low
    input  logic                 req_valid_i,
    input  dbus_pkg::word_t      req_addr_i,
    input  logic                 req_write_i,
    input  dbus_pkg::word_t      req_data_i,
    input  dbus_pkg::byte_mask_t req_mask_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output dbus_pkg::word_t      resp_data_o,
    input  logic                 resp_ready_i
);

    import dbus_pkg::*;

    word_t      mem [word_t];
    logic [7:0] lfsr;
    logic       ready_q;
    logic [1:0] req_wait;
    logic       rd_pending;
    logic [1:0] resp_wait;
    word_t      rd_addr;

    assign req_ready_o = ready_q && !hold_ready_i;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // one step per bit taken
    function automatic logic [1:0] draw_delay();
        logic [1:0] d;
        lfsr = lfsr_next(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        d[1] = lfsr[0];
        return d;
    endfunction

    // unwritten words read back as a function of the whole address
    function automatic word_t fill_pattern(input word_t a);
        return {a[15:0] ^ a[31:16], ~a[15:0]};
    endfunction

    function automatic word_t read_word(input word_t a);
        return mem.exists(a) ? mem[a] : fill_pattern(a);
    endfunction

    always @(posedge clk_i) begin
        word_t w;
        if (!rstn_i) begin
            lfsr         = 8'd78;
            ready_q      <= 1'b0;
            req_wait     <= draw_delay();
            rd_pending   <= 1'b0;
            resp_wait    <= 2'd0;
            resp_valid_o <= 1'b0;
            resp_data_o  <= '0;
        end else begin
            if (req_valid_i && req_ready_o) begin
                ready_q  <= 1'b0;
                req_wait <= draw_delay();
                if (req_write_i) begin
                    w = read_word(req_addr_i);
                    for (int b = 0; b < `MEM_BYTES; b++) begin
                        if (req_mask_i[b]) w[8*b +: 8] = req_data_i[8*b +: 8];
                    end
                    mem[req_addr_i] = w;
                end else begin
                    rd_pending <= 1'b1;
                    rd_addr    <= req_addr_i;
                    resp_wait  <= draw_delay();
                end
            end else if (req_valid_i && !ready_q) begin
                if (req_wait == 2'd0) ready_q <= 1'b1;
                else req_wait <= req_wait - 2'd1;
            end

            if (resp_valid_o && resp_ready_i) begin
                resp_valid_o <= 1'b0;
            end else if (rd_pending) begin
                if (resp_wait == 2'd0) begin
                    resp_valid_o <= 1'b1;
                    resp_data_o  <= read_word(rd_addr);
                    rd_pending   <= 1'b0;
                end else begin
                    resp_wait <= resp_wait - 2'd1;
                end
            end
        end
    end

endmodule

/* tb_mem_stage.sv */
`timescale 1ns/10ps

`include "mem_defs.svh"

module tb_mem_stage;

    import uop_pkg::*;
    import dbus_pkg::*;

    localparam int NUM_OPS = 40;

    logic                clk_i;
    logic                rstn_i;
    logic                uop_valid_i;
    mem_op_e             uop_op_i;
    word_t               uop_addr_i;
    word_t               uop_wdata_i;
    logic [`RD_BITS-1:0] uop_rd_i;
    tag_t                uop_tag_i;
    logic                hold_ready;
    logic                stall_o;
    logic                wb_valid_o;
    logic                wb_we_o;
    logic [`RD_BITS-1:0] wb_rd_o;
    word_t               wb_data_o;
    tag_t                wb_tag_o;
    logic                l1d_req_valid_o;
    word_t               l1d_req_addr_o;
    logic                l1d_req_write_o;
    word_t               l1d_req_data_o;
    byte_mask_t          l1d_req_mask_o;
    logic                l1d_req_uncached_o;
    logic                l1d_req_ready;
    logic                l1d_resp_valid;
    word_t               l1d_resp_data;
    logic                l1d_resp_ready_o;

    // last request transfer seen
    word_t      req_addr;
    logic       req_write;
    word_t      req_data;
    byte_mask_t req_mask;
    logic       req_uncached;
    logic       req_seen;
    word_t      ref_mem [word_t];
    int         tag_ctr;

    mem_stage u_dut (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .uop_valid_i(uop_valid_i), .uop_op_i(uop_op_i), .uop_addr_i(uop_addr_i),
        .uop_wdata_i(uop_wdata_i), .uop_rd_i(uop_rd_i), .uop_tag_i(uop_tag_i),
        .stall_o(stall_o),
        .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o), .wb_rd_o(wb_rd_o),
        .wb_data_o(wb_data_o), .wb_tag_o(wb_tag_o),
        .l1d_req_valid_o(l1d_req_valid_o), .l1d_req_addr_o(l1d_req_addr_o),
        .l1d_req_write_o(l1d_req_write_o), .l1d_req_data_o(l1d_req_data_o),
        .l1d_req_mask_o(l1d_req_mask_o), .l1d_req_uncached_o(l1d_req_uncached_o),
        .l1d_req_ready_i(l1d_req_ready), .l1d_resp_valid_i(l1d_resp_valid),
        .l1d_resp_data_i(l1d_resp_data), .l1d_resp_ready_o(l1d_resp_ready_o)
    );

    tb_dcache_model u_cache (
        .clk_i(clk_i), .rstn_i(rstn_i), .hold_ready_i(hold_ready),
        .req_valid_i(l1d_req_valid_o), .req_addr_i(l1d_req_addr_o),
        .req_write_i(l1d_req_write_o), .req_data_i(l1d_req_data_o),
        .req_mask_i(l1d_req_mask_o), .req_ready_o(l1d_req_ready),
        .resp_valid_o(l1d_resp_valid), .resp_data_o(l1d_resp_data),
        .resp_ready_i(l1d_resp_ready_o)
    );

    always #4 clk_i = ~clk_i;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp)
        else report_fail($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic word_t untouched_word(input word_t a);
        return {a[15:0] ^ a[31:16], ~a[15:0]};
    endfunction

    function automatic word_t ref_read(input word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        return ref_mem.exists(wa) ? ref_mem[wa] : untouched_word(wa);
    endfunction

    // lane b takes its byte from the store size and its mask bit from size and offset
    task automatic store_expect(input mem_op_e op, input logic [1:0] lo, input word_t rs2,
                                output word_t d, output byte_mask_t m);
        for (int b = 0; b < 4; b++) begin
            case (op)
                SB: begin
                    d[8*b +: 8] = rs2[7:0];
                    m[b] = (b == lo);
                end
                SH: begin
                    d[8*b +: 8] = rs2[8*(b%2) +: 8];
                    m[b] = (b/2 == lo/2);
                end
                default: begin
                    d[8*b +: 8] = rs2[8*b +: 8];
                    m[b] = 1'b1;
                end
            endcase
        end
    endtask

    function automatic word_t load_expect(input mem_op_e op, input word_t a);
        word_t       w;
        logic [7:0]  b;
        logic [15:0] h;
        w = ref_read(a);
        b = w[8*a[1:0] +: 8];
        h = w[8*a[1:0] +: 16];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return w;
        endcase
    endfunction

    // drives one uop with the cache ready optionally forced low and checks writeback
    task automatic run_uop(input mem_op_e op, input word_t addr, input word_t wdata,
                           input int hold_cycles);
        int                  n;
        logic                done;
        word_t               snap_addr;
        word_t               snap_data;
        byte_mask_t          snap_mask;
        logic [`RD_BITS-1:0] rd;
        tag_t                tag;
        n = 0;
        done = 1'b0;
        req_seen = 1'b0;
        tag_ctr++;
        rd = `RD_BITS'(tag_ctr + 1);
        tag = tag_t'(tag_ctr);
        @(posedge clk_i);
        uop_valid_i <= 1'b1;
        uop_op_i    <= op;
        uop_addr_i  <= addr;
        uop_wdata_i <= wdata;
        uop_rd_i    <= rd;
        uop_tag_i   <= tag;
        hold_ready  <= (hold_cycles > 0);
        while (!done) begin
            @(negedge clk_i);
            n++;
            if (l1d_req_valid_o && l1d_req_ready) begin
                req_seen     = 1'b1;
                req_addr     = l1d_req_addr_o;
                req_write    = l1d_req_write_o;
                req_data     = l1d_req_data_o;
                req_mask     = l1d_req_mask_o;
                req_uncached = l1d_req_uncached_o;
            end
            if (n <= hold_cycles) begin
                check_value("stall_o", stall_o, 1);
                check_value("l1d_req_valid_o", l1d_req_valid_o, 1);
                if (n == 1) begin
                    snap_addr = l1d_req_addr_o;
                    snap_data = l1d_req_data_o;
                    snap_mask = l1d_req_mask_o;
                end
                check_value("l1d_req_addr_o", l1d_req_addr_o, snap_addr);
                check_value("l1d_req_data_o", l1d_req_data_o, snap_data);
                check_value("l1d_req_mask_o", l1d_req_mask_o, snap_mask);
            end
            check_value("wb_valid_o", wb_valid_o, 0);  // nothing retires before the accept edge
            if (!stall_o) begin
                check_value("l1d_resp_ready_o", l1d_resp_ready_o, op inside {LB, LBU, LH, LHU, LW});
                done = 1'b1;
            end else if (n == hold_cycles) begin
                @(posedge clk_i);
                hold_ready <= 1'b0;
            end
        end
        @(posedge clk_i);
        uop_valid_i <= 1'b0;
        @(negedge clk_i);
        check_value("wb_valid_o", wb_valid_o, 1);
        check_value("wb_rd_o", wb_rd_o, rd);
        check_value("wb_tag_o", wb_tag_o, tag);
        check_value("wb_we_o", wb_we_o, !(op inside {SB, SH, SW}));
        assert (req_seen == (op != NONE))
        else report_fail("request to the cache did not match the op kind");
    endtask

    task automatic store_and_track(input mem_op_e op, input word_t addr, input word_t rs2);
        word_t      d;
        byte_mask_t m;
        word_t      w;
        run_uop(op, addr, rs2, 0);
        store_expect(op, addr[1:0], rs2, d, m);
        check_value("l1d_req_addr_o", req_addr, {addr[31:2], 2'b00});
        check_value("l1d_req_write_o", req_write, 1);
        check_value("l1d_req_data_o", req_data, d);
        check_value("l1d_req_mask_o", req_mask, m);
        check_value("l1d_req_uncached_o", req_uncached, addr >= `IO_BASE);
        w = ref_read(addr);
        for (int b = 0; b < 4; b++) begin
            if (m[b]) w[8*b +: 8] = d[8*b +: 8];
        end
        ref_mem[{addr[31:2], 2'b00}] = w;
    endtask

    task automatic load_and_compare(input mem_op_e op, input word_t addr, input int hold_cycles);
        run_uop(op, addr, 32'h0, hold_cycles);
        check_value("l1d_req_addr_o", req_addr, {addr[31:2], 2'b00});
        check_value("l1d_req_write_o", req_write, 0);
        check_value("l1d_req_mask_o", req_mask, 0);
        check_value("l1d_req_uncached_o", req_uncached, addr >= `IO_BASE);
        check_value("wb_data_o", wb_data_o, load_expect(op, addr));
    endtask

    task automatic reset_outputs();
        check_value("wb_valid_o", wb_valid_o, 0);
        check_value("l1d_req_valid_o", l1d_req_valid_o, 0);
        check_value("stall_o", stall_o, 0);
        check_value("l1d_resp_ready_o", l1d_resp_ready_o, 0);
    endtask

    task automatic non_mem_passthrough();
        word_t results [4] = '{32'h0000_0001, 32'hDEAD_BEEF, 32'h7FFF_FFFF, 32'h1234_5678};
        foreach (results[i]) begin
            run_uop(NONE, results[i], 32'h0, 0);
            check_value("wb_data_o", wb_data_o, results[i]);  // alu result
        end
    endtask

    task automatic store_lanes();
        for (int off = 0; off < 4; off++) begin
            store_and_track(SB, 32'h0000_0100 + off, 32'hA0 + off);
            load_and_compare(LW, 32'h0000_0100, 0);
        end
        store_and_track(SH, 32'h0000_0104, 32'h1111_C3B2);
        load_and_compare(LW, 32'h0000_0104, 0);
        store_and_track(SH, 32'h0000_0106, 32'h2222_8E7D);
        load_and_compare(LW, 32'h0000_0104, 0);
        store_and_track(SW, 32'h0000_0108, 32'hCAFE_F00D);
        load_and_compare(LW, 32'h0000_0108, 0);
    endtask

    task automatic load_extension();
        store_and_track(SW, 32'h0000_0200, 32'h80F1_7F82);
        for (int off = 0; off < 4; off++) begin
            load_and_compare(LB, 32'h0000_0200 + off, 0);
            load_and_compare(LBU, 32'h0000_0200 + off, 0);
        end
        for (int off = 0; off < 4; off += 2) begin
            load_and_compare(LH, 32'h0000_0200 + off, 0);
            load_and_compare(LHU, 32'h0000_0200 + off, 0);
        end
    endtask

    task automatic ready_backpressure();
        run_uop(SW, 32'h0000_0300, 32'h5A5A_0FF0, 5);
        ref_mem[32'h0000_0300] = 32'h5A5A_0FF0;
        load_and_compare(LW, 32'h0000_0300, 4);
    endtask

    task automatic io_window();
        store_and_track(SW, 32'hF000_0010, 32'h0BAD_CAFE);
        load_and_compare(LW, 32'hF000_0010, 0);
        store_and_track(SW, 32'hEFFF_FFFC, 32'h0000_BEEF);
        load_and_compare(LW, 32'hEFFF_FFFC, 0);
    endtask

    initial begin
        repeat (NUM_OPS * 12 + 100) @(posedge clk_i);
        report_fail("watchdog expired, the stage never finished a handshake");
    end

    initial begin
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        uop_valid_i = 1'b0;
        uop_op_i    = NONE;
        uop_addr_i  = '0;
        uop_wdata_i = '0;
        uop_rd_i    = '0;
        uop_tag_i   = '0;
        hold_ready  = 1'b0;
        tag_ctr     = 0;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_outputs();
        @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        reset_outputs();
        non_mem_passthrough();
        store_lanes();
        load_extension();
        ready_backpressure();
        io_window();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
dbus_pkg.sv
uop_pkg.sv
store_format.sv
load_align.sv
dbus_port.sv
mem_stage_ctrl.sv
mem_stage.sv
tb_dcache_model.sv
tb_mem_stage.sv

/* run.sh */
#!/bin/sh
# build and run the memory stage testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_mem_stage -o tb_mem_stage \
    && ./obj_dir/tb_mem_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
